//--- include/rv_exec_params.svh
//==============================
// Integer execution unit sizing
// Data width and register file geometry
//==============================

`ifndef RV_EXEC_PARAMS_SVH
`define RV_EXEC_PARAMS_SVH

// Architectural data width
`define RV_XLEN 32

// Number of integer registers, x0 included
`define RV_REG_COUNT 32

// Bits needed to index one register
`define RV_REG_AW 5

`endif

//--- hdl/rv_exec_pkg.sv
//==============================
// Integer execution unit types
// Opcodes, ALU operations, decode and retire records
//==============================

`include "rv_exec_params.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // Major opcodes handled by the unit, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // ALU operations, PASS_B forwards operand b untouched
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // Decoder output, fanned out by the top level
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;     // Operand b from the immediate
        logic      use_pc;      // Operand a from the pc
        logic      rd_we;       // Never set for x0
        logic      illegal;
    } decoded_t;

    // One retired instruction
    typedef struct packed {
        reg_addr_t rd;
        word_t     result;
        logic      rd_we;
        logic      illegal;
        word_t     pc;
    } retire_t;

endpackage

//--- hdl/reg_file.sv
//==============================
// Integer register file
// Two combinational reads, one clocked write, x0 reads zero
//==============================

`include "rv_exec_params.svh"

module reg_file (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    // Write port driven from the result register
    input  logic                   write_en_i,
    input  rv_exec_pkg::reg_addr_t rd_addr_i,
    input  rv_exec_pkg::word_t     rd_data_i,

    // Read ports
    input  rv_exec_pkg::reg_addr_t rs1_addr_i,
    input  rv_exec_pkg::reg_addr_t rs2_addr_i,
    output rv_exec_pkg::word_t     rs1_data_o,
    output rv_exec_pkg::word_t     rs2_data_o
);

    // One storage word per architectural register
    rv_exec_pkg::word_t regs_q [`RV_REG_COUNT];

    //==============================
    // Write port
    //==============================
    // All registers come out of reset as zero
    // The decoder never requests a write to x0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (write_en_i) begin
            regs_q[rd_addr_i] <= rd_data_i;
        end
    end

    //==============================
    // Read ports
    //==============================
    // Reads see the array before this cycle's write lands
    // Index zero is forced to zero regardless of storage
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

//--- hdl/instr_decoder.sv
//==============================
// RV32I decoder for OP, OP-IMM, LUI and AUIPC
// Fields, immediate, ALU operation and legality
//==============================

module instr_decoder (
    input  rv_exec_pkg::word_t    instr_i,
    output rv_exec_pkg::decoded_t dec_o
);

    rv_exec_pkg::opcode_e opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    rv_exec_pkg::word_t   imm_i_type;
    rv_exec_pkg::word_t   imm_u_type;
    logic                 illegal;

    // Raw fields
    assign opcode = rv_exec_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // Sign-extended I-type and upper U-type immediates
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u_type = {instr_i[31:12], 12'b0};

    //==============================
    // Opcode and function decode
    //==============================
    always_comb begin
        // Register fields are passed through for every format
        dec_o.rs1 = instr_i[19:15];
        dec_o.rs2 = instr_i[24:20];
        dec_o.rd  = instr_i[11:7];

        // Unknown words default to PASS_B of a zero immediate
        // so an illegal instruction retires with a zero result
        dec_o.imm     = '0;
        dec_o.alu_op  = rv_exec_pkg::ALU_PASS_B;
        dec_o.use_imm = 1'b1;
        dec_o.use_pc  = 1'b0;
        illegal       = 1'b0;

        case (opcode)
            rv_exec_pkg::OPC_OP, rv_exec_pkg::OPC_OP_IMM: begin
                dec_o.use_imm = (opcode == rv_exec_pkg::OPC_OP_IMM);
                dec_o.imm     = imm_i_type;
                case (funct3)
                    3'b000: begin
                        // SUB only exists in the register form
                        if (opcode == rv_exec_pkg::OPC_OP && funct7[5]) begin
                            dec_o.alu_op = rv_exec_pkg::ALU_SUB;
                        end else begin
                            dec_o.alu_op = rv_exec_pkg::ALU_ADD;
                        end
                    end
                    3'b001:  dec_o.alu_op = rv_exec_pkg::ALU_SLL;
                    3'b010:  dec_o.alu_op = rv_exec_pkg::ALU_SLT;
                    3'b011:  dec_o.alu_op = rv_exec_pkg::ALU_SLTU;
                    3'b100:  dec_o.alu_op = rv_exec_pkg::ALU_XOR;
                    3'b101: begin
                        dec_o.alu_op = funct7[5] ? rv_exec_pkg::ALU_SRA
                                                 : rv_exec_pkg::ALU_SRL;
                    end
                    3'b110:  dec_o.alu_op = rv_exec_pkg::ALU_OR;
                    default: dec_o.alu_op = rv_exec_pkg::ALU_AND;
                endcase

                // funct7 legality
                // OP: zero, or 0100000 on ADD/SUB and SRL/SRA
                // OP-IMM: only the shifts carry a funct7 field
                if (opcode == rv_exec_pkg::OPC_OP) begin
                    illegal = !((funct7 == 7'b0000000) ||
                                (funct7 == 7'b0100000 &&
                                 (funct3 == 3'b000 || funct3 == 3'b101)));
                end else if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            rv_exec_pkg::OPC_LUI: begin
                dec_o.imm = imm_u_type;
            end
            rv_exec_pkg::OPC_AUIPC: begin
                dec_o.imm    = imm_u_type;
                dec_o.alu_op = rv_exec_pkg::ALU_ADD;
                dec_o.use_pc = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        // Keep the imm fallback at zero when the word is rejected
        if (illegal) begin
            dec_o.imm     = '0;
            dec_o.alu_op  = rv_exec_pkg::ALU_PASS_B;
            dec_o.use_imm = 1'b1;
            dec_o.use_pc  = 1'b0;
        end

        // No write for illegal words or x0
        dec_o.illegal = illegal;
        dec_o.rd_we   = !illegal && (instr_i[11:7] != '0);
    end

endmodule

//--- hdl/int_alu.sv
//==============================
// Integer ALU
// Combinational RV32I arithmetic, logic, shifts and compares
//==============================

module int_alu (
    input  rv_exec_pkg::alu_op_e op_i,
    input  rv_exec_pkg::word_t   a_i,
    input  rv_exec_pkg::word_t   b_i,
    output rv_exec_pkg::word_t   result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Shift amount from the low five bits of b
    assign shamt = b_i[4:0];

    // Compares shared by SLT and SLTU
    assign lt_signed   = ($signed(a_i) < $signed(b_i));
    assign lt_unsigned = (a_i < b_i);

    //==============================
    // Operation select
    //==============================
    always_comb begin
        case (op_i)
            rv_exec_pkg::ALU_ADD: begin
                result_o = a_i + b_i;
            end
            rv_exec_pkg::ALU_SUB: begin
                result_o = a_i - b_i;
            end
            rv_exec_pkg::ALU_SLL: begin
                result_o = a_i << shamt;
            end
            rv_exec_pkg::ALU_SLT: begin
                // Zero-extended flag
                result_o = rv_exec_pkg::word_t'(lt_signed);
            end
            rv_exec_pkg::ALU_SLTU: begin
                result_o = rv_exec_pkg::word_t'(lt_unsigned);
            end
            rv_exec_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            rv_exec_pkg::ALU_SRL:    result_o = a_i >> shamt;
            rv_exec_pkg::ALU_SRA: begin
                // Arithmetic shift keeps the sign bit
                result_o = rv_exec_pkg::word_t'($signed(a_i) >>> shamt);
            end
            rv_exec_pkg::ALU_OR:     result_o = a_i | b_i;
            rv_exec_pkg::ALU_AND:    result_o = a_i & b_i;
            rv_exec_pkg::ALU_PASS_B: result_o = b_i;
            // Unused encodings
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

//--- hdl/writeback_bypass.sv
//==============================
// Result register with writeback and forwarding
// Drives the register file write port and the retire outputs
//==============================

module writeback_bypass (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    // Instruction in execute this cycle
    input  logic                   valid_i,
    input  rv_exec_pkg::decoded_t  dec_i,
    input  rv_exec_pkg::word_t     pc_i,
    input  rv_exec_pkg::word_t     result_i,

    // Register file read data and forwarded operands
    input  rv_exec_pkg::word_t     rf_rs1_i,
    input  rv_exec_pkg::word_t     rf_rs2_i,
    output rv_exec_pkg::word_t     rs1_val_o,
    output rv_exec_pkg::word_t     rs2_val_o,

    // Register file write port
    output logic                   rf_we_o,
    output rv_exec_pkg::reg_addr_t rf_waddr_o,
    output rv_exec_pkg::word_t     rf_wdata_o,

    // Retirement
    output logic                   retire_valid_o,
    output rv_exec_pkg::retire_t   retire_o
);

    logic                 valid_q;
    rv_exec_pkg::retire_t wb_q;
    logic                 wb_write;

    //==============================
    // Result register
    //==============================
    // Valid bit is the only control state
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // Payload loads only on an accepted strobe
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wb_q.rd      <= dec_i.rd;
            wb_q.result  <= result_i;
            wb_q.rd_we   <= dec_i.rd_we;
            wb_q.illegal <= dec_i.illegal;
            wb_q.pc      <= pc_i;
        end
    end

    // A pending write commits at the end of the retire cycle
    assign wb_write   = valid_q && wb_q.rd_we;
    assign rf_we_o    = wb_write;
    assign rf_waddr_o = wb_q.rd;
    assign rf_wdata_o = wb_q.result;

    //==============================
    // Forwarding
    //==============================
    // The register file still holds the old value this cycle
    // rd is never x0 when wb_write is set, so x0 reads stay zero
    assign rs1_val_o = (wb_write && wb_q.rd == dec_i.rs1) ? wb_q.result : rf_rs1_i;
    assign rs2_val_o = (wb_write && wb_q.rd == dec_i.rs2) ? wb_q.result : rf_rs2_i;

    assign retire_valid_o = valid_q;
    assign retire_o       = wb_q;

endmodule

//--- hdl/int_exec_unit.sv
//==============================
// RV32I integer execution unit
// Decode, read, execute, retire one instruction per strobe
//==============================

module int_exec_unit (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 instr_valid_i,
    input  rv_exec_pkg::word_t   instr_i,
    output logic                 retire_valid_o,
    output rv_exec_pkg::retire_t retire_o
);

    rv_exec_pkg::word_t     pc_q;
    rv_exec_pkg::decoded_t  dec;
    rv_exec_pkg::word_t     rf_rs1;
    rv_exec_pkg::word_t     rf_rs2;
    rv_exec_pkg::word_t     rs1_val;
    rv_exec_pkg::word_t     rs2_val;
    rv_exec_pkg::word_t     alu_a;
    rv_exec_pkg::word_t     alu_b;
    rv_exec_pkg::word_t     alu_result;
    logic                   rf_we;
    rv_exec_pkg::reg_addr_t rf_waddr;
    rv_exec_pkg::word_t     rf_wdata;

    // Program counter, one word per accepted strobe
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= '0;
        end else if (instr_valid_i) begin
            pc_q <= pc_q + rv_exec_pkg::word_t'(4);
        end
    end

    instr_decoder i_instr_decoder (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    reg_file i_reg_file (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .write_en_i (rf_we),
        .rd_addr_i  (rf_waddr),
        .rd_data_i  (rf_wdata),
        .rs1_addr_i (dec.rs1),
        .rs2_addr_i (dec.rs2),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2)
    );

    // Operand selects, pc for AUIPC and the immediate for I/U types
    assign alu_a = dec.use_pc  ? pc_q    : rs1_val;
    assign alu_b = dec.use_imm ? dec.imm : rs2_val;

    int_alu i_int_alu (
        .op_i     (dec.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    writeback_bypass i_writeback_bypass (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .valid_i        (instr_valid_i),
        .dec_i          (dec),
        .pc_i           (pc_q),
        .result_i       (alu_result),
        .rf_rs1_i       (rf_rs1),
        .rf_rs2_i       (rf_rs2),
        .rs1_val_o      (rs1_val),
        .rs2_val_o      (rs2_val),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

//--- verification/int_exec_assert.sv
//==============================
// Integer execution unit assertions
// Bound into the top level
//==============================

module int_exec_assert (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   instr_valid_i,
    input logic                   retire_valid_i,
    input logic                   rf_we_i,
    input rv_exec_pkg::reg_addr_t rf_waddr_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Register file never receives a write to x0
    a_no_x0_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
        rf_we_i |-> (rf_waddr_i != '0))
        else $error("register file write to x0");

    // No strobe means no retirement on the next cycle
    a_no_spurious_retire : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !instr_valid_i |=> !retire_valid_i)
        else $error("retirement without a preceding strobe");

    // Quiet outputs while reset is held
    a_quiet_in_reset : assert property (@(posedge clk_i)
        !rst_ni |-> !retire_valid_i)
        else $error("retire_valid_o high during reset");

endmodule

bind int_exec_unit int_exec_assert i_int_exec_assert (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .retire_valid_i (retire_valid_o),
    .rf_we_i        (rf_we),
    .rf_waddr_i     (rf_waddr)
);

//--- verification/int_exec_checker.sv
//==============================
// Reference model and retirement checker
//==============================

module int_exec_checker (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 instr_valid_i,
    input  rv_exec_pkg::word_t   instr_i,
    input  logic                 retire_valid_i,
    input  rv_exec_pkg::retire_t retire_i,
    output int                   errors_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0]          model_regs [32];
    logic [31:0]          model_pc;
    rv_exec_pkg::retire_t exp_q [$];

    // RV32I arithmetic by funct3, alt selects SUB or SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction on the model state
    function automatic rv_exec_pkg::retire_t execute(input logic [31:0] ins);
        rv_exec_pkg::retire_t r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] immi;
        logic [31:0] immu;
        f3   = ins[14:12];
        f7   = ins[31:25];
        immi = {{20{ins[31]}}, ins[31:20]};
        immu = {ins[31:12], 12'd0};
        r.rd = ins[11:7];
        r.pc = model_pc;
        r.illegal = 1'b0;
        r.result = '0;
        case (ins[6:0])
            7'h33: begin
                r.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                r.result  = alu_ref(f3, f7[5], model_regs[ins[19:15]], model_regs[ins[24:20]]);
            end
            7'h13: begin
                if (f3 == 3'd1) r.illegal = (f7 != 7'h00);
                if (f3 == 3'd5) r.illegal = (f7 != 7'h00 && f7 != 7'h20);
                r.result = alu_ref(f3, f3 == 3'd5 && f7[5], model_regs[ins[19:15]], immi);
            end
            7'h37:   r.result = immu;
            7'h17:   r.result = model_pc + immu;
            default: r.illegal = 1'b1;
        endcase
        r.rd_we = !r.illegal && (r.rd != 5'd0);
        if (r.rd_we) model_regs[r.rd] = r.result;
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            errors_o++;
        end
    endtask

    initial errors_o = 0;

    always @(posedge clk_i or negedge rst_ni) begin
        rv_exec_pkg::retire_t e;
        if (!rst_ni) begin
            foreach (model_regs[i]) model_regs[i] = '0;
            model_pc = '0;
            exp_q.delete();
        end else begin
            // Retirement belongs to the strobe of the previous edge
            if (retire_valid_i && exp_q.size() == 0) begin
                $display("Unexpected retirement at %0t with no accepted instruction", $time);
                errors_o++;
            end else if (retire_valid_i) begin
                e = exp_q.pop_front();
                compare("retire_o.rd", 32'(e.rd), 32'(retire_i.rd));
                compare("retire_o.rd_we", 32'(e.rd_we), 32'(retire_i.rd_we));
                compare("retire_o.illegal", 32'(e.illegal), 32'(retire_i.illegal));
                compare("retire_o.pc", e.pc, retire_i.pc);
                if (!e.illegal) compare("retire_o.result", e.result, retire_i.result);
            end else if (exp_q.size() != 0) begin
                $display("Missing retirement at %0t for the instruction at pc %h",
                         $time, exp_q[0].pc);
                errors_o++;
                void'(exp_q.pop_front());
            end
            if (instr_valid_i) begin
                exp_q.push_back(execute(instr_i));
                model_pc = model_pc + 32'd4;
            end
        end
    end

endmodule

//--- verification/tb_int_exec_unit.sv
//==============================
// Integer execution unit testbench
// Random RV32I stimulus checked against a model
//==============================

module tb_int_exec_unit;
    timeunit 1ns;
    timeprecision 1ps;

    // Upper bound of cycles over all tests
    // Sparse gaps add at most 3 idle cycles per strobe
    localparam int total_cycles = 16 + 400 * 4 + 300 + 200 * 2 + 100 * 2 + 108 * 2 + 60 + 6 * 4;

    logic                 clk_i = 1'b0;
    logic                 rst_ni;
    logic                 instr_valid_i;
    rv_exec_pkg::word_t   instr_i;
    logic                 retire_valid_o;
    rv_exec_pkg::retire_t retire_o;
    int                   errors;
    int                   tests_passed = 0;
    int                   tests_failed = 0;
    logic [31:0]          rng_state = 32'he26b08ce;
    logic [4:0]           last_rd = 5'd0;

    // 10 ns clock
    always #5 clk_i = ~clk_i;

    int_exec_unit i_int_exec_unit (
        .clk_i, .rst_ni, .instr_valid_i, .instr_i, .retire_valid_o, .retire_o
    );

    // Reference model and comparison of every retirement
    int_exec_checker i_int_exec_checker (
        .clk_i, .rst_ni, .instr_valid_i, .instr_i,
        .retire_valid_i (retire_valid_o),
        .retire_i       (retire_o),
        .errors_o       (errors)
    );

    // Xorshift generator, 13/17/5 taps
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Register draws stay in x0..x7 to force dependencies
    function automatic logic [4:0] small_reg();
        logic [31:0] r;
        r = next_rand();
        return {2'b00, r[2:0]};
    endfunction

    // Register form with a legal funct7 for the chosen funct3
    function automatic logic [31:0] make_op(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        logic [31:0] r;
        logic [2:0]  f3;
        r  = next_rand();
        f3 = r[2:0];
        return {(f3 == 3'd0 || f3 == 3'd5) && r[3] ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
    endfunction

    // Immediate form, shifts keep a legal funct7 in imm[11:5]
    function automatic logic [31:0] make_op_imm(input logic [4:0] rd, input logic [4:0] rs1);
        logic [31:0] r;
        logic [11:0] imm;
        r   = next_rand();
        imm = r[31:20];
        if (r[2:0] == 3'd1) imm[11:5] = 7'h00;
        if (r[2:0] == 3'd5) imm[11:5] = r[3] ? 7'h20 : 7'h00;
        return {imm, rs1, r[2:0], rd, 7'h13};
    endfunction

    // Bad funct7 on OP, bad funct7 on SLLI, or an unsupported opcode
    function automatic logic [31:0] make_illegal();
        logic [31:0] r;
        r = next_rand();
        case (r[1:0])
            2'd0: return {7'h01 | {r[31:26], 1'b0}, r[24:7], 7'h33};
            2'd1: return {7'h40, r[24:15], 3'd1, r[11:7], 7'h13};
            default: begin
                if (r[6:0] inside {7'h33, 7'h13, 7'h37, 7'h17}) r[6:0] = 7'h03;
                return r;
            end
        endcase
    endfunction

    // Idle for gap cycles and then send one strobe
    task automatic issue(input logic [31:0] ins, input int gap);
        repeat (gap) begin
            @(posedge clk_i);
            instr_valid_i <= 1'b0;
        end
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        last_rd = ins[11:7];
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            instr_valid_i <= 1'b0;
        end
    endtask

    // ADDI x0 reads a register back through the result
    task automatic read_back(input int first, input int last);
        for (int i = first; i <= last; i++) issue({12'd0, 5'(i), 3'd0, 5'd0, 7'h13}, 0);
    endtask

    // Drains the last retirement before the error count is read
    task automatic finish_test(input string name, input int errors_before);
        idle(3);
        if (errors == errors_before) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail, %0d errors", name, errors - errors_before);
        end
    endtask

    //==============================
    // Watchdog
    //==============================
    initial begin
        #(total_cycles * 10 + 2000);
        $display("Timeout: the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    //==============================
    // Test sequence
    //==============================
    initial begin
        int e;
        logic [31:0] r;
        rst_ni        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;

        // Mixed OP and OP-IMM with sparse strobes
        e = errors;
        for (int i = 0; i < 400; i++) begin
            r = next_rand();
            issue(r[0] ? make_op(small_reg(), small_reg(), small_reg())
                       : make_op_imm(small_reg(), small_reg()),
                  (r[3:2] == 2'd0) ? 0 : int'(r[5:4]));
        end
        finish_test("arithmetic", e);

        // Every instruction reads the previous rd
        e = errors;
        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            issue(r[0] ? make_op(small_reg(), r[1] ? last_rd : small_reg(), last_rd)
                       : make_op_imm(small_reg(), last_rd), 0);
        end
        finish_test("back_to_back", e);

        // x0 as destination and as source
        e = errors;
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            issue(r[0] ? make_op(r[1] ? 5'd0 : small_reg(), r[2] ? 5'd0 : small_reg(), 5'd0)
                       : make_op_imm(r[1] ? 5'd0 : small_reg(), 5'd0), int'(r[4:3] == 2'd0));
        end
        finish_test("x0", e);

        // Upper immediates, AUIPC adds the strobe count times 4
        e = errors;
        for (int i = 0; i < 100; i++) begin
            r = next_rand();
            issue({r[31:12], small_reg(), r[0] ? 7'h37 : 7'h17}, int'(r[2:1] == 2'd0));
        end
        finish_test("lui_auipc", e);

        // Rejected words, then the touched registers read back
        e = errors;
        for (int i = 0; i < 100; i++) issue(make_illegal(), next_rand() & 1);
        read_back(0, 7);
        finish_test("illegal", e);

        // Mid-run reset, then every register read back
        e = errors;
        idle(2);
        rst_ni <= 1'b0;
        idle(4);
        rst_ni <= 1'b1;
        read_back(0, 31);
        finish_test("reset", e);

        $display("Tests passed: %0d, tests failed: %0d, checker errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
hdl/rv_exec_pkg.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/int_alu.sv
hdl/writeback_bypass.sv
hdl/int_exec_unit.sv
verification/int_exec_assert.sv
verification/int_exec_checker.sv
verification/tb_int_exec_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_int_exec_unit
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
